//--- music_player.f
+incdir+common
common/music_pkg.sv
logic/milli_timer.sv
logic/tone_generator.sv
logic/seg7_decoder.sv
song/song_rom.sv
song/song_sequencer.sv
logic/music_player.sv
verification/tb_clock_gen.sv
verification/music_player_assertions.sv
verification/music_player_tb.sv

//--- Makefile
TOP := music_player_tb

SRCS := $(wildcard common/* logic/* song/* verification/*)

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+100 | awk '{ print } /TEST PASS/ { ok = 1 } END { exit !ok }'

obj_dir/V$(TOP): music_player.f $(SRCS)
	verilator --binary --timing --assert -f music_player.f --top-module $(TOP)

lint:
	verilator --lint-only --timing --assert -f music_player.f --top-module $(TOP)

clean:
	rm -rf obj_dir

//--- verification/music_player_tb.sv
/* plays the whole song once plus the wrap to part 1 at 20 cycles per ms
   outputs are sampled on the falling clock edge */
`timescale 1ns/10ps
`default_nettype none

`include "music_cfg.svh"

module music_player_tb;
  import music_pkg::*;

  localparam int TPM = 20;   // cycles per ms

  logic       clk;
  logic       rst;
  ms_t        ticks_per_milli;
  logic       sound;
  logic       note_on;
  logic [6:0] segments;

  // song copy with rows for intro, verse and chorus
  int beats_tab [3][6] = '{'{2, 2, 1, 3, 0, 0}, '{1, 2, 1, 1, 1, 3}, '{1, 1, 3, 2, 1, 2}};
  int freq_tab  [3][6] = '{'{554, 622, 0, 415, 0, 0}, '{277, 311, 0, 261, 233, 208},
                           '{466, 415, 698, 622, 554, 0}};
  int notes_tab [3] = '{`INTRO_LEN, `VERSE_LEN, `CHORUS_LEN};
  logic [6:0] digit_tab [7] = '{7'b0000000, 7'b0000110, 7'b1011011, 7'b1001111,
                                7'b1100110, 7'b1101101, 7'b1111100};

  tb_clock_gen u_clk (
    .clk(clk),
    .rst(rst)
  );

  music_player dut (
    .clk            (clk),
    .rst            (rst),
    .ticks_per_milli(ticks_per_milli),
    .sound          (sound),
    .note_on        (note_on),
    .segments       (segments)
  );

  function automatic int sec_of(input int p);
    return (p <= 2) ? 0 : (((p % 2) == 1) ? 1 : 2);   // 3,5 verse and 4,6 chorus
  endfunction

  function automatic int len_ms(input int p, input int i);
    return beats_tab[sec_of(p)][i] * `BEAT_MS * ((sec_of(p) == 1) ? 2 : 1);
  endfunction

  function automatic int watchdog_cycles();
    int total;
    int len;
    int p;
    total = 100;   // reset and start-up
    for (int k = 0; k <= `NUM_PARTS; k++) begin
      p = (k == `NUM_PARTS) ? 1 : k + 1;   // one extra part after the wrap
      for (int i = 0; i < notes_tab[sec_of(p)]; i++) begin
        len = len_ms(p, i);
        total += len * TPM + 1 + (len / 3) * TPM + 2;
      end
    end
    return total;
  endfunction

  task automatic fail_run();
    $display("TEST FAIL");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic expect_eq(input string test, input int expected, input int actual);
    if (expected != actual) begin
      $display("Mismatch %s: expected %0d, actual %0d", test, expected, actual);
      fail_run();
    end
  endtask

  task automatic expect_near(input string test, input int expected, input int actual);
    if (actual < expected - 1 || actual > expected + 1) begin
      $display("Mismatch %s: expected %0d +/- 1, actual %0d", test, expected, actual);
      fail_run();
    end
  endtask

  // counts falling edges and sound toggles while note_on stays at level
  task automatic measure(input logic level, input logic silent, output int cycles,
                         output int toggles);
    logic last;
    cycles  = 0;
    toggles = 0;
    last    = sound;
    while (note_on === level) begin
      if (silent && sound !== 1'b0) begin
        $display("sound is not silent during a rest note");
        fail_run();
      end
      if (sound !== last) begin
        toggles++;
      end
      last = sound;
      cycles++;
      @(negedge clk);
    end
  endtask

  initial begin : drive_inputs
    ticks_per_milli <= '0;
    @(posedge clk);
    ticks_per_milli <= ms_t'(TPM);
  end

  initial begin : watchdog
    repeat (watchdog_cycles()) @(posedge clk);
    $display("timeout: the song did not come back to part 1 in time");
    fail_run();
  end

  initial begin : assertion_watch
    wait (dut.u_chk.failed === 1'b1);
    $display("a bound assertion failed, see the error above");
    fail_run();
  end

  initial begin : run_song
    int hi;
    int lo;
    int len;
    int freq;
    int toggles;
    @(negedge clk);
    while (rst !== 1'b0) @(negedge clk);
    measure(1'b0, 1'b0, lo, toggles);
    expect_eq("start delay", 1, lo);
    for (int p = 1; p <= `NUM_PARTS; p++) begin
      for (int i = 0; i < notes_tab[sec_of(p)]; i++) begin
        len  = len_ms(p, i);
        freq = freq_tab[sec_of(p)][i];
        expect_eq($sformatf("part %0d digit", p), int'(digit_tab[p]), int'(segments));
        measure(1'b1, freq == 0, hi, toggles);
        expect_eq($sformatf("part %0d note %0d length", p, i), len * TPM + 1, hi);
        if (freq != 0) begin
          // two toggles per period of the note
          expect_near($sformatf("part %0d note %0d toggles", p, i),
                      len * freq * 2 / `MS_PER_SEC, toggles);
        end
        measure(1'b0, 1'b0, lo, toggles);
        expect_eq($sformatf("part %0d note %0d gap", p, i), (len / 3) * TPM + 2, lo);
      end
    end
    expect_eq("wrap digit", int'(digit_tab[1]), int'(segments));
    if (dut.u_chk.failed === 1'b0) begin
      $display("TEST PASS");
      $finish;
    end else begin
      $display("a bound assertion failed before the end of the song");
      fail_run();
    end
  end

endmodule

`default_nettype wire

//--- verification/music_player_assertions.sv
/* checker bound into music_player; pitch intervals are only measured
   between two toggles of the same note */
`timescale 1ns/10ps
`default_nettype none

module music_player_assertions (
  input  wire               clk,
  input  wire               rst,
  input  music_pkg::ms_t    ticks_per_milli,
  input  music_pkg::freq_t  tone_freq,
  input  wire               sound,
  input  wire               note_on,
  input  wire [6:0]         segments
);
  import music_pkg::*;

  logic [31:0] half_sec;
  logic [31:0] lo_gap;
  logic [31:0] hi_gap;
  logic [31:0] run_len;            // cycles since sound last changed
  logic        had_toggle;         // a toggle already seen in this note
  logic        sound_d;
  logic        fired_reset   = 1'b0;
  logic        fired_silence = 1'b0;
  logic        fired_pitch   = 1'b0;
  logic        fired_display = 1'b0;
  logic        failed;

  assign half_sec = 32'(ticks_per_milli) * 32'd500;   // half a second of cycles
  assign failed   = fired_reset | fired_silence | fired_pitch | fired_display;

  always_comb begin
    lo_gap = '0;
    hi_gap = '0;
    if (tone_freq != '0) begin
      lo_gap = half_sec / 32'(tone_freq);
      hi_gap = (half_sec + 32'(tone_freq) - 32'd1) / 32'(tone_freq);
    end
  end

  always_ff @(posedge clk) begin
    sound_d <= sound;
    if (rst || !note_on) begin
      run_len    <= '0;
      had_toggle <= 1'b0;
    end else if (sound != sound_d) begin
      run_len    <= 32'd1;
      had_toggle <= 1'b1;
    end else begin
      run_len <= run_len + 32'd1;
    end
  end

  reset_idle: assert property (@(posedge clk)
      $fell(rst) |-> (!sound && !note_on && segments == 7'b0000110))
    else begin
      fired_reset = 1'b1;
      $error("outputs are not idle with digit 1 after reset");
    end

  silent_when_off: assert property (@(posedge clk) disable iff (rst) !note_on |-> !sound)
    else begin
      fired_silence = 1'b1;
      $error("sound is active while note_on is low");
    end

  pitch_interval: assert property (@(posedge clk) disable iff (rst)
      (note_on && had_toggle && sound != sound_d) |-> (run_len >= lo_gap && run_len <= hi_gap))
    else begin
      fired_pitch = 1'b1;
      $error("toggle interval %0d outside %0d..%0d", run_len, lo_gap, hi_gap);
    end

  display_steady: assert property (@(posedge clk) disable iff (rst) note_on |-> $stable(segments))
    else begin
      fired_display = 1'b1;
      $error("display changed during a note");
    end

endmodule

bind music_player music_player_assertions u_chk (
  .clk            (clk),
  .rst            (rst),
  .ticks_per_milli(ticks_per_milli),
  .tone_freq      (tone_freq),
  .sound          (sound),
  .note_on        (note_on),
  .segments       (segments)
);

`default_nettype wire

//--- verification/tb_clock_gen.sv
/* free-running 40 ns clock; rst is high until the 4th rising edge */
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;   // 40 ns period
  end

  initial begin
    rst = 1'b1;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

`default_nettype wire

//--- logic/music_player.sv
/* melody player top; ticks_per_milli must be >= 2 and held stable
   playback starts at part 1 one cycle after reset */
`timescale 1ns/10ps
`default_nettype none

module music_player (
  input  wire             clk,
  input  wire             rst,
  input  music_pkg::ms_t  ticks_per_milli,
  output logic            sound,
  output logic            note_on,
  output logic [6:0]      segments
);
  import music_pkg::*;

  section_t  section;
  note_idx_t note_idx;
  note_idx_t section_len;
  note_t     note;
  ms_t       elapsed_ms;
  logic      ms_restart;
  freq_t     tone_freq;
  part_t     part;

  song_sequencer u_seq (
    .clk        (clk),
    .rst        (rst),
    .section    (section),
    .note_idx   (note_idx),
    .note       (note),
    .section_len(section_len),
    .elapsed_ms (elapsed_ms),
    .ms_restart (ms_restart),
    .tone_freq  (tone_freq),
    .note_on    (note_on),
    .part       (part)
  );

  song_rom u_rom (
    .section    (section),
    .note_idx   (note_idx),
    .note       (note),
    .section_len(section_len)
  );

  milli_timer u_timer (
    .clk            (clk),
    .rst            (rst),
    .ticks_per_milli(ticks_per_milli),
    .ms_restart     (ms_restart),
    .elapsed_ms     (elapsed_ms)
  );

  tone_generator u_tone (
    .clk            (clk),
    .rst            (rst),
    .ticks_per_milli(ticks_per_milli),
    .freq           (tone_freq),
    .sound          (sound)
  );

  seg7_decoder u_seg7 (
    .part    (part),
    .segments(segments)
  );

endmodule

`default_nettype wire

//--- song/song_sequencer.sv
/* walks parts 1..6, notes and load/sound/gap phases, wraps after part 6
   gap after each note is a third of its length, rounded down */
`timescale 1ns/10ps
`default_nettype none

`include "music_cfg.svh"

module song_sequencer (
  input  wire                   clk,
  input  wire                   rst,
  output music_pkg::section_t   section,
  output music_pkg::note_idx_t  note_idx,
  input  music_pkg::note_t      note,
  input  music_pkg::note_idx_t  section_len,
  input  music_pkg::ms_t        elapsed_ms,
  output logic                  ms_restart,
  output music_pkg::freq_t      tone_freq,
  output logic                  note_on,
  output music_pkg::part_t      part
);
  import music_pkg::*;

  phase_t phase;
  ms_t    note_len;   // latched in PH_LOAD
  ms_t    load_len;
  ms_t    gap_len;
  logic   sound_done;
  logic   gap_done;
  logic   last_note;

  // part to section map
  always_comb begin
    case (part)
      3'd1, 3'd2: section = SEC_INTRO;
      3'd3, 3'd5: section = SEC_VERSE;
      default:    section = SEC_CHORUS;   // parts 4 and 6
    endcase
  end

  always_comb begin
    load_len = ms_t'(note.beats * `BEAT_MS);
    if (section == SEC_VERSE) begin
      load_len = load_len << 1;   // verse notes last twice as long
    end
  end

  assign gap_len    = ms_t'(note_len / 3);
  assign sound_done = (phase == PH_SOUND) && (elapsed_ms == note_len);
  assign gap_done   = (phase == PH_GAP) && (elapsed_ms == gap_len);
  assign last_note  = (note_idx == section_len);

  // timer restarts when a note starts and when its gap starts
  assign ms_restart = (phase == PH_LOAD) || sound_done;

  always_ff @(posedge clk) begin
    if (phase == PH_LOAD) begin
      note_len <= load_len;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      phase     <= PH_LOAD;
      part      <= part_t'(1);
      note_idx  <= '0;
      note_on   <= 1'b0;
      tone_freq <= '0;
    end else begin
      case (phase)
        PH_LOAD: begin
          note_on   <= 1'b1;        // lamp runs for rests too
          tone_freq <= note.freq;   // 0 for a rest
          phase     <= PH_SOUND;
        end
        PH_SOUND: begin
          if (sound_done) begin
            note_on   <= 1'b0;
            tone_freq <= '0;
            phase     <= PH_GAP;
          end
        end
        PH_GAP: begin
          if (gap_done) begin
            phase <= PH_LOAD;
            if (last_note) begin
              note_idx <= '0;
              if (part == part_t'(`NUM_PARTS)) begin
                part <= part_t'(1);   // wrap to intro
              end else begin
                part <= part + part_t'(1);
              end
            end else begin
              note_idx <= note_idx + note_idx_t'(1);
            end
          end
        end
        default: begin
          phase     <= PH_LOAD;
          note_on   <= 1'b0;
          tone_freq <= '0;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- song/song_rom.sv
/* constant note tables, combinational lookup
   section_len is the last valid index; indexes past it read a rest */
`timescale 1ns/10ps
`default_nettype none

`include "music_cfg.svh"

module song_rom (
  input  music_pkg::section_t   section,
  input  music_pkg::note_idx_t  note_idx,
  output music_pkg::note_t      note,
  output music_pkg::note_idx_t  section_len
);
  import music_pkg::*;

  always_comb begin
    note        = '0;
    section_len = '0;
    case (section)
      SEC_INTRO: begin
        section_len = note_idx_t'(`INTRO_LEN - 1);
        case (note_idx)
          3'd0:    note = '{freq: 10'd554, beats: 4'd2};   // c5s
          3'd1:    note = '{freq: 10'd622, beats: 4'd2};   // e5f
          3'd2:    note = '{freq: 10'd0,   beats: 4'd1};   // rest
          3'd3:    note = '{freq: 10'd415, beats: 4'd3};   // a4f
          default: note = '0;
        endcase
      end
      SEC_VERSE: begin
        section_len = note_idx_t'(`VERSE_LEN - 1);
        case (note_idx)
          3'd0:    note = '{freq: 10'd277, beats: 4'd1};   // c4s
          3'd1:    note = '{freq: 10'd311, beats: 4'd2};   // e4f
          3'd2:    note = '{freq: 10'd0,   beats: 4'd1};   // rest
          3'd3:    note = '{freq: 10'd261, beats: 4'd1};   // c4
          3'd4:    note = '{freq: 10'd233, beats: 4'd1};   // b3f
          3'd5:    note = '{freq: 10'd208, beats: 4'd3};   // a3f
          default: note = '0;
        endcase
      end
      SEC_CHORUS: begin
        section_len = note_idx_t'(`CHORUS_LEN - 1);
        case (note_idx)
          3'd0:    note = '{freq: 10'd466, beats: 4'd1};   // b4f
          3'd1:    note = '{freq: 10'd415, beats: 4'd1};   // a4f
          3'd2:    note = '{freq: 10'd698, beats: 4'd3};   // f5
          3'd3:    note = '{freq: 10'd622, beats: 4'd2};   // e5f
          3'd4:    note = '{freq: 10'd554, beats: 4'd1};   // c5s
          3'd5:    note = '{freq: 10'd0,   beats: 4'd2};   // rest
          default: note = '0;
        endcase
      end
      default: begin
        note        = '0;
        section_len = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- logic/seg7_decoder.sv
/* digits 1 to 6 only, anything else blanks the display
   bit 0 is segment a, bit 6 is segment g */
`timescale 1ns/10ps
`default_nettype none

module seg7_decoder (
  input  music_pkg::part_t  part,
  output logic [6:0]        segments
);

  //     -a-
  //    f   b
  //     -g-
  //    e   c
  //     -d-
  always_comb begin
    case (part)
      3'd1:    segments = 7'b0000110;
      3'd2:    segments = 7'b1011011;
      3'd3:    segments = 7'b1001111;
      3'd4:    segments = 7'b1100110;
      3'd5:    segments = 7'b1101101;
      3'd6:    segments = 7'b1111100;   // six without the top bar
      default: segments = 7'b0000000;   // blank
    endcase
  end

endmodule

`default_nettype wire

//--- logic/tone_generator.sv
/* square wave by phase accumulation; toggles every half period
   freq 0 silences the output and clears the accumulator */
`timescale 1ns/10ps
`default_nettype none

`include "music_cfg.svh"

module tone_generator (
  input  wire               clk,
  input  wire               rst,
  input  music_pkg::ms_t    ticks_per_milli,
  input  music_pkg::freq_t  freq,
  output logic              sound
);

  logic [31:0] acc;
  logic [31:0] half_sec;   // ticks in half a second
  logic        sound_q;

  assign half_sec = 32'(ticks_per_milli) * 32'(`MS_PER_SEC / 2);

  always_ff @(posedge clk) begin
    if (rst || freq == '0) begin
      acc     <= '0;
      sound_q <= 1'b0;
    end else if (acc >= half_sec) begin
      acc     <= acc + 32'(freq) - half_sec;   // keep the remainder
      sound_q <= ~sound_q;
    end else begin
      acc <= acc + 32'(freq);
    end
  end

  // silent in the same cycle the frequency drops to 0
  assign sound = sound_q && (freq != '0);

endmodule

`default_nettype wire

//--- logic/milli_timer.sv
/* elapsed-ms counter; ticks_per_milli must be >= 2 and stable
   restart clears both counts in the following cycle */
`timescale 1ns/10ps
`default_nettype none

module milli_timer (
  input  wire              clk,
  input  wire              rst,
  input  music_pkg::ms_t   ticks_per_milli,
  input  wire              ms_restart,
  output music_pkg::ms_t   elapsed_ms
);
  import music_pkg::*;

  ms_t tick_cnt;   // prescaler counting clk cycles
  logic ms_tick;

  assign ms_tick = (tick_cnt == ticks_per_milli - ms_t'(1));

  always_ff @(posedge clk) begin
    if (rst) begin
      tick_cnt   <= '0;
      elapsed_ms <= '0;
    end else if (ms_restart) begin
      tick_cnt   <= '0;
      elapsed_ms <= '0;
    end else if (ms_tick) begin
      tick_cnt   <= '0;
      elapsed_ms <= elapsed_ms + ms_t'(1);   // one more ms
    end else begin
      tick_cnt <= tick_cnt + ms_t'(1);
    end
  end

endmodule

`default_nettype wire

//--- common/music_pkg.sv
/* shared types of the melody player; widths come from music_cfg.svh
   frequency 0 encodes a rest */
`default_nettype none

`include "music_cfg.svh"

package music_pkg;

  typedef logic [`FREQ_W-1:0] freq_t;    // 0 = rest
  typedef logic [`MS_W-1:0]   ms_t;

  typedef struct packed {
    freq_t               freq;
    logic [`BEATS_W-1:0] beats;
  } note_t;

  typedef enum logic [1:0] {SEC_INTRO, SEC_VERSE, SEC_CHORUS} section_t;

  typedef logic [2:0] part_t;       // 1..6
  typedef logic [2:0] note_idx_t;   // index inside a section

  typedef enum logic [1:0] {PH_LOAD, PH_SOUND, PH_GAP} phase_t;

endpackage

`default_nettype wire

//--- common/music_cfg.svh
/* song and timing sizes; BEAT_MS sets the tempo
   section lengths must match the tables in song_rom */
`ifndef MUSIC_CFG_SVH
`define MUSIC_CFG_SVH

`define FREQ_W      10    // note frequency in Hz
`define BEATS_W     4     // note length in beats
`define MS_W        16    // durations in ms

`define BEAT_MS     100   // ms per beat before the verse doubling
`define INTRO_LEN   4
`define VERSE_LEN   6
`define CHORUS_LEN  6
`define NUM_PARTS   6
`define MS_PER_SEC  1000

`endif
